/* logic/isa_pkg.sv */
// opcode values and field layout of the 32-bit instruction set; there is no NOP opcode
package isa_pkg;

  // meaningful widths
  typedef logic [31:0] word_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [4:0]  sub_opcode_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [1:0]  sv_t;

  localparam int NUM_REGS = 32;

  // major opcodes
  localparam opcode_t TYPE_BASIC = 6'b100000;
  localparam opcode_t TYPE_LS    = 6'b011100;
  localparam opcode_t ADDI       = 6'b101000;
  localparam opcode_t ORI        = 6'b101100;
  localparam opcode_t XORI       = 6'b101011;
  localparam opcode_t MOVI       = 6'b100010;
  localparam opcode_t BEQ        = 6'b100110;
  localparam opcode_t J          = 6'b100100;
  localparam opcode_t LWI        = 6'b000010;
  localparam opcode_t SWI        = 6'b001010;

  // basic group sub-opcodes
  localparam sub_opcode_t ADD   = 5'b00000;
  localparam sub_opcode_t SUB   = 5'b00001;
  localparam sub_opcode_t AND   = 5'b00010;
  localparam sub_opcode_t OR    = 5'b00100;
  localparam sub_opcode_t XOR   = 5'b00011;
  localparam sub_opcode_t SLLI  = 5'b01000;
  localparam sub_opcode_t SRLI  = 5'b01001;
  localparam sub_opcode_t ROTRI = 5'b01011;

  // load/store group sub-opcodes
  localparam sub_opcode_t LW = 5'b00010;
  localparam sub_opcode_t SW = 5'b01010;

  // instruction field positions with bit 31 unused
  localparam int OPCODE_MSB = 30;
  localparam int OPCODE_LSB = 25;
  localparam int RT_MSB     = 24;
  localparam int RT_LSB     = 20;
  localparam int RA_MSB     = 19;
  localparam int RA_LSB     = 15;
  // rb and the shift amount share this field
  localparam int RB_MSB     = 14;
  localparam int RB_LSB     = 10;
  localparam int SV_MSB     = 9;
  localparam int SV_LSB     = 8;
  localparam int SUB_MSB    = 4;
  localparam int SUB_LSB    = 0;

  // immediates start at bit 0
  localparam int IMM15_W = 15;
  localparam int IMM20_W = 20;

endpackage

/* logic/alu32.sv */
// purely combinational; undefined ops give 0 with flags low, shifts use scr2[4:0] only
`timescale 1ns/1ns

module alu32 (
  input  isa_pkg::opcode_t     opcode,
  input  isa_pkg::sub_opcode_t sub_opcode,
  input  isa_pkg::sv_t         sv,
  input  isa_pkg::word_t       scr1,
  input  isa_pkg::word_t       scr2,
  output isa_pkg::word_t       alu_result,
  output logic                 alu_overflow,
  output logic                 zero
);

  isa_pkg::word_t add_sum;
  isa_pkg::word_t sub_diff;
  logic [4:0]     shamt;
  logic [63:0]    rot;
  logic           add_ovf;
  logic           sub_ovf;
  logic           is_arith;

  assign add_sum  = scr1 + scr2;
  assign sub_diff = scr1 - scr2;

  // signed overflow from the sign bits
  assign add_ovf = (scr1[31] == scr2[31]) && (add_sum[31] != scr1[31]);
  assign sub_ovf = (scr1[31] != scr2[31]) && (sub_diff[31] != scr1[31]);

  assign shamt = scr2[4:0];
  assign rot   = {scr1, scr1} >> shamt;

  // only these ops may flag overflow
  assign is_arith = (opcode == isa_pkg::ADDI) ||
                    ((opcode == isa_pkg::TYPE_BASIC) &&
                     ((sub_opcode == isa_pkg::ADD) || (sub_opcode == isa_pkg::SUB)));

  always_comb begin
    alu_result   = '0;
    alu_overflow = 1'b0;
    zero         = 1'b0;
    case (opcode)
      isa_pkg::TYPE_BASIC: begin
        case (sub_opcode)
          isa_pkg::ADD: begin
            alu_result   = add_sum;
            alu_overflow = add_ovf;
          end
          isa_pkg::SUB: begin
            alu_result   = sub_diff;
            alu_overflow = sub_ovf;
          end
          isa_pkg::AND:   alu_result = scr1 & scr2;
          isa_pkg::OR:    alu_result = scr1 | scr2;
          isa_pkg::XOR:   alu_result = scr1 ^ scr2;
          isa_pkg::SLLI:  alu_result = scr1 << shamt;
          isa_pkg::SRLI:  alu_result = scr1 >> shamt;
          // rotate right through the doubled word
          isa_pkg::ROTRI: alu_result = rot[31:0];
          default:        alu_result = '0;
        endcase
      end
      isa_pkg::ADDI: begin
        alu_result   = add_sum;
        alu_overflow = add_ovf;
      end
      isa_pkg::ORI:  alu_result = scr1 | scr2;
      isa_pkg::XORI: alu_result = scr1 ^ scr2;
      isa_pkg::MOVI: alu_result = scr2;
      isa_pkg::BEQ:  zero = (scr1 == scr2);
      isa_pkg::J:    zero = 1'b1;
      // word-scaled immediate address
      isa_pkg::LWI,
      isa_pkg::SWI:  alu_result = scr1 + (scr2 << 2);
      isa_pkg::TYPE_LS: begin
        case (sub_opcode)
          isa_pkg::LW,
          isa_pkg::SW: alu_result = scr1 + (scr2 << sv);
          default:     alu_result = '0;
        endcase
      end
      default: begin
        alu_result   = '0;
        alu_overflow = 1'b0;
        zero         = 1'b0;
      end
    endcase
  end

  // overflow outside the arithmetic ops
  always_comb begin
    a_ovf_only_arith: assert final (!alu_overflow || is_arith)
      else $error("overflow raised by an op other than ADD, SUB or ADDI");
  end

endmodule

/* logic/instr_decoder.sv */
// combinational field split; for BEQ the rb read port is steered to rt
`timescale 1ns/1ns

module instr_decoder (
  input  isa_pkg::word_t       instr,
  input  isa_pkg::word_t       ra_data,
  input  isa_pkg::word_t       rb_data,
  output isa_pkg::reg_idx_t    ra_idx,
  output isa_pkg::reg_idx_t    rb_idx,
  output isa_pkg::reg_idx_t    rt_idx,
  output logic                 wb_en,
  output isa_pkg::opcode_t     opcode,
  output isa_pkg::sub_opcode_t sub_opcode,
  output isa_pkg::sv_t         sv,
  output isa_pkg::word_t       scr1,
  output isa_pkg::word_t       scr2
);

  isa_pkg::reg_idx_t             rb_field;
  logic [isa_pkg::IMM15_W-1:0]   imm15;
  logic [isa_pkg::IMM20_W-1:0]   imm20;
  isa_pkg::word_t                imm15_sext;
  isa_pkg::word_t                imm15_zext;
  isa_pkg::word_t                imm20_sext;
  isa_pkg::word_t                shamt_zext;

  // fixed fields
  assign opcode     = instr[isa_pkg::OPCODE_MSB:isa_pkg::OPCODE_LSB];
  assign rt_idx     = instr[isa_pkg::RT_MSB:isa_pkg::RT_LSB];
  assign ra_idx     = instr[isa_pkg::RA_MSB:isa_pkg::RA_LSB];
  assign rb_field   = instr[isa_pkg::RB_MSB:isa_pkg::RB_LSB];
  assign sv         = instr[isa_pkg::SV_MSB:isa_pkg::SV_LSB];
  assign sub_opcode = instr[isa_pkg::SUB_MSB:isa_pkg::SUB_LSB];
  assign imm15      = instr[isa_pkg::IMM15_W-1:0];
  assign imm20      = instr[isa_pkg::IMM20_W-1:0];

  // BEQ compares ra against rt
  assign rb_idx = (opcode == isa_pkg::BEQ) ? rt_idx : rb_field;

  // immediate extensions
  assign imm15_sext = {{($bits(isa_pkg::word_t) - isa_pkg::IMM15_W){imm15[isa_pkg::IMM15_W-1]}},
                       imm15};
  assign imm15_zext = {{($bits(isa_pkg::word_t) - isa_pkg::IMM15_W){1'b0}}, imm15};
  assign imm20_sext = {{($bits(isa_pkg::word_t) - isa_pkg::IMM20_W){imm20[isa_pkg::IMM20_W-1]}},
                       imm20};
  assign shamt_zext = {{($bits(isa_pkg::word_t) - $bits(isa_pkg::reg_idx_t)){1'b0}}, rb_field};

  assign scr1 = ra_data;

  always_comb begin
    scr2  = rb_data;
    wb_en = 1'b0;
    case (opcode)
      isa_pkg::TYPE_BASIC: begin
        case (sub_opcode)
          isa_pkg::ADD,
          isa_pkg::SUB,
          isa_pkg::AND,
          isa_pkg::OR,
          isa_pkg::XOR: wb_en = 1'b1;
          isa_pkg::SLLI,
          isa_pkg::SRLI,
          isa_pkg::ROTRI: begin
            scr2  = shamt_zext;
            wb_en = 1'b1;
          end
          // undefined sub-opcode writes nothing
          default: wb_en = 1'b0;
        endcase
      end
      isa_pkg::ADDI: begin
        scr2  = imm15_sext;
        wb_en = 1'b1;
      end
      isa_pkg::ORI,
      isa_pkg::XORI: begin
        scr2  = imm15_zext;
        wb_en = 1'b1;
      end
      isa_pkg::MOVI: begin
        scr2  = imm20_sext;
        wb_en = 1'b1;
      end
      // address only with nothing written back
      isa_pkg::LWI,
      isa_pkg::SWI: scr2 = imm15_sext;
      default: begin
        scr2  = rb_data;
        wb_en = 1'b0;
      end
    endcase
  end

endmodule

/* logic/reg_file.sv */
// two async read ports, one write port; reset clears all entries over one clock
`timescale 1ns/1ns

module reg_file (
  input  logic              clk,
  input  logic              reset,
  input  isa_pkg::reg_idx_t ra_idx,
  input  isa_pkg::reg_idx_t rb_idx,
  output isa_pkg::word_t    ra_data,
  output isa_pkg::word_t    rb_data,
  input  logic              wr_en,
  input  isa_pkg::reg_idx_t wr_idx,
  input  isa_pkg::word_t    wr_data
);

  isa_pkg::word_t regs [isa_pkg::NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // combinational reads see the old value during a write cycle
  assign ra_data = regs[ra_idx];
  assign rb_data = regs[rb_idx];

  // write index comes from the latched instruction in the control block
  a_wr_idx_known: assert property (
    @(posedge clk) disable iff (reset)
    wr_en |-> !$isunknown(wr_idx)
  ) else $error("register write with unknown index");

endmodule

/* logic/exec_control.sv */
// four-phase req/ack; one instruction in flight, outputs hold until the next ack
`timescale 1ns/1ns

module exec_control (
  input  logic              clk,
  input  logic              reset,
  input  logic              req,
  input  isa_pkg::word_t    instr,
  output logic              ack,
  output isa_pkg::word_t    cur_instr,
  input  logic              wb_en,
  input  isa_pkg::reg_idx_t rt_idx,
  input  isa_pkg::word_t    alu_result,
  input  logic              alu_overflow,
  input  logic              zero,
  output logic              wr_en,
  output isa_pkg::reg_idx_t wr_idx,
  output isa_pkg::word_t    wr_data,
  output isa_pkg::word_t    result,
  output logic              overflow,
  output logic              taken
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_ACK
  } state_t;

  state_t state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ST_IDLE;
      ack      <= 1'b0;
      result   <= '0;
      overflow <= 1'b0;
      taken    <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req) begin
            state <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          // capture the alu outputs as ack goes up
          result   <= alu_result;
          overflow <= alu_overflow;
          taken    <= zero;
          ack      <= 1'b1;
          state    <= ST_ACK;
        end
        ST_ACK: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // instruction latch loaded on acceptance
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req) begin
      cur_instr <= instr;
    end
  end

  // write strobe for the exec cycle only
  assign wr_en   = (state == ST_EXEC) && wb_en;
  assign wr_idx  = rt_idx;
  assign wr_data = alu_result;

  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (reset)
    $rose(ack) |-> $past(req)
  ) else $error("ack raised without a pending req");

  a_wr_single: assert property (
    @(posedge clk) disable iff (reset)
    wr_en |=> !wr_en
  ) else $error("write strobe held for more than one cycle");

endmodule

/* logic/exec_stage.sv */
// no hazard handling; loads and stores only report their address
`timescale 1ns/1ns

module exec_stage (
  input  logic           clk,
  input  logic           reset,
  input  logic           req,
  input  isa_pkg::word_t instr,
  output logic           ack,
  output isa_pkg::word_t result,
  output logic           overflow,
  output logic           taken
);

  isa_pkg::word_t       cur_instr;
  isa_pkg::reg_idx_t    ra_idx;
  isa_pkg::reg_idx_t    rb_idx;
  isa_pkg::reg_idx_t    rt_idx;
  isa_pkg::word_t       ra_data;
  isa_pkg::word_t       rb_data;
  logic                 wb_en;
  isa_pkg::opcode_t     opcode;
  isa_pkg::sub_opcode_t sub_opcode;
  isa_pkg::sv_t         sv;
  isa_pkg::word_t       scr1;
  isa_pkg::word_t       scr2;
  isa_pkg::word_t       alu_result;
  logic                 alu_overflow;
  logic                 zero;
  logic                 wr_en;
  isa_pkg::reg_idx_t    wr_idx;
  isa_pkg::word_t       wr_data;

  exec_control i_control (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .instr        (instr),
    .ack          (ack),
    .cur_instr    (cur_instr),
    .wb_en        (wb_en),
    .rt_idx       (rt_idx),
    .alu_result   (alu_result),
    .alu_overflow (alu_overflow),
    .zero         (zero),
    .wr_en        (wr_en),
    .wr_idx       (wr_idx),
    .wr_data      (wr_data),
    .result       (result),
    .overflow     (overflow),
    .taken        (taken)
  );

  instr_decoder i_decoder (
    .instr      (cur_instr),
    .ra_data    (ra_data),
    .rb_data    (rb_data),
    .ra_idx     (ra_idx),
    .rb_idx     (rb_idx),
    .rt_idx     (rt_idx),
    .wb_en      (wb_en),
    .opcode     (opcode),
    .sub_opcode (sub_opcode),
    .sv         (sv),
    .scr1       (scr1),
    .scr2       (scr2)
  );

  reg_file i_reg_file (
    .clk     (clk),
    .reset   (reset),
    .ra_idx  (ra_idx),
    .rb_idx  (rb_idx),
    .ra_data (ra_data),
    .rb_data (rb_data),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_data (wr_data)
  );

  alu32 i_alu (
    .opcode       (opcode),
    .sub_opcode   (sub_opcode),
    .sv           (sv),
    .scr1         (scr1),
    .scr2         (scr2),
    .alu_result   (alu_result),
    .alu_overflow (alu_overflow),
    .zero         (zero)
  );

endmodule

/* dv/tb_clock_gen.sv */
// 100 ns clock from time 0; reset high over the first two rising edges, released on a falling edge
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  localparam int HALF_PERIOD = 50;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
  end

endmodule

/* dv/exec_stage_tb.sv */
// r0 is never written by the tests; a 32-bit constant is loaded with MOVI, SLLI and ORI
`timescale 1ns/1ns

module exec_stage_tb;

  // upper bound on instructions issued for the watchdog
  localparam int NUM_INSTR  = 300;
  localparam int CLK_PERIOD = 100;
  localparam isa_pkg::sub_opcode_t BASIC_OPS [8] = '{isa_pkg::ADD, isa_pkg::SUB, isa_pkg::AND,
    isa_pkg::OR, isa_pkg::XOR, isa_pkg::SLLI, isa_pkg::SRLI, isa_pkg::ROTRI};

  logic           clk;
  logic           reset;
  logic           req;
  isa_pkg::word_t instr;
  logic           ack;
  isa_pkg::word_t result;
  logic           overflow;
  logic           taken;
  isa_pkg::word_t model_regs [isa_pkg::NUM_REGS];
  integer         seed;

  tb_clock_gen i_clk_gen (
    .clk   (clk),
    .reset (reset)
  );

  exec_stage i_dut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .instr    (instr),
    .ack      (ack),
    .result   (result),
    .overflow (overflow),
    .taken    (taken)
  );

  // bit 31 left at zero
  function automatic isa_pkg::word_t enc(isa_pkg::opcode_t op, isa_pkg::reg_idx_t rt,
                                         isa_pkg::reg_idx_t ra, logic [14:0] low);
    isa_pkg::word_t w;
    w = '0;
    w[isa_pkg::OPCODE_MSB:isa_pkg::OPCODE_LSB] = op;
    w[isa_pkg::RT_MSB:isa_pkg::RT_LSB]         = rt;
    w[isa_pkg::RA_MSB:isa_pkg::RA_LSB]         = ra;
    w[isa_pkg::IMM15_W-1:0]                    = low;
    return w;
  endfunction

  // rb or shift amount, sv, sub-opcode
  function automatic logic [14:0] rfields(isa_pkg::reg_idx_t rb, isa_pkg::sv_t sv,
                                          isa_pkg::sub_opcode_t sub);
    logic [14:0] f;
    f = '0;
    f[isa_pkg::RB_MSB:isa_pkg::RB_LSB]   = rb;
    f[isa_pkg::SV_MSB:isa_pkg::SV_LSB]   = sv;
    f[isa_pkg::SUB_MSB:isa_pkg::SUB_LSB] = sub;
    return f;
  endfunction

  function automatic longint sext64(isa_pkg::word_t v);
    return {{32{v[31]}}, v};
  endfunction

  // one bit position per step
  function automatic isa_pkg::word_t rotr(isa_pkg::word_t v, logic [4:0] n);
    isa_pkg::word_t r;
    r = v;
    for (int i = 0; i < 32; i++) begin
      if (i < int'(n)) r = {r[0], r[31:1]};
    end
    return r;
  endfunction

  // reference model that also updates the model registers
  task automatic predict(input isa_pkg::word_t w, output isa_pkg::word_t res,
                         output logic ovf, output logic tk);
    isa_pkg::opcode_t     op;
    isa_pkg::sub_opcode_t sub;
    isa_pkg::word_t       a;
    isa_pkg::word_t       b;
    isa_pkg::word_t       simm;
    longint               wide;
    logic                 arith;
    logic                 wb;
    op    = w[30:25];
    sub   = w[4:0];
    a     = model_regs[w[19:15]];
    b     = model_regs[w[14:10]];
    simm  = {{17{w[14]}}, w[14:0]};
    res   = '0;
    tk    = 1'b0;
    wide  = 0;
    arith = (op == isa_pkg::ADDI) ||
            (op == isa_pkg::TYPE_BASIC && (sub == isa_pkg::ADD || sub == isa_pkg::SUB));
    wb    = (op == isa_pkg::ADDI) || (op == isa_pkg::ORI) || (op == isa_pkg::XORI) ||
            (op == isa_pkg::MOVI);
    case (op)
      isa_pkg::TYPE_BASIC: begin
        wb = 1'b1;
        case (sub)
          isa_pkg::ADD:   wide = sext64(a) + sext64(b);
          isa_pkg::SUB:   wide = sext64(a) - sext64(b);
          isa_pkg::AND:   res = a & b;
          isa_pkg::OR:    res = a | b;
          isa_pkg::XOR:   res = a ^ b;
          isa_pkg::SLLI:  res = a << w[14:10];
          isa_pkg::SRLI:  res = a >> w[14:10];
          isa_pkg::ROTRI: res = rotr(a, w[14:10]);
          default:        wb = 1'b0;
        endcase
      end
      isa_pkg::ADDI: wide = sext64(a) + sext64(simm);
      isa_pkg::ORI:  res = a | {17'b0, w[14:0]};
      isa_pkg::XORI: res = a ^ {17'b0, w[14:0]};
      isa_pkg::MOVI: res = {{12{w[19]}}, w[19:0]};
      isa_pkg::BEQ:  tk = (a == model_regs[w[24:20]]);
      isa_pkg::J:    tk = 1'b1;
      isa_pkg::LWI,
      isa_pkg::SWI:  res = a + (simm << 2);
      isa_pkg::TYPE_LS: begin
        if (sub == isa_pkg::LW || sub == isa_pkg::SW) res = a + (b << w[9:8]);
      end
      default: res = '0;
    endcase
    if (arith) res = wide[31:0];
    // signed overflow when the wide sum does not fit in 32 bits
    ovf = arith && (wide[63:31] != '0) && (wide[63:31] != '1);
    if (wb) model_regs[w[24:20]] = res;
  endtask

  task automatic check_word(input string what, input isa_pkg::word_t got,
                            input isa_pkg::word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Done: errors found");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("Done: errors found");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // full four-phase transfer with req optionally held for extra cycles
  task automatic run_instr(input isa_pkg::word_t w, input int hold);
    isa_pkg::word_t exp_res;
    logic           exp_ovf;
    logic           exp_tk;
    predict(w, exp_res, exp_ovf, exp_tk);
    @(negedge clk);
    req   = 1'b1;
    instr = w;
    @(negedge clk);
    while (!ack) @(negedge clk);
    check_word("result", result, exp_res);
    check_flag("overflow", overflow, exp_ovf);
    check_flag("taken", taken, exp_tk);
    repeat (hold) begin
      @(negedge clk);
      check_flag("ack while req held", ack, 1'b1);
      check_word("result while req held", result, exp_res);
      check_flag("overflow while req held", overflow, exp_ovf);
      check_flag("taken while req held", taken, exp_tk);
    end
    req = 1'b0;
    // the edge that samples req low drops ack
    @(negedge clk);
    check_flag("ack after req low", ack, 1'b0);
  endtask

  task automatic load_reg(input isa_pkg::reg_idx_t r, input isa_pkg::word_t v);
    run_instr(enc(isa_pkg::MOVI, r, {{3{v[31]}}, v[31:30]}, v[29:15]), 0);
    run_instr(enc(isa_pkg::TYPE_BASIC, r, r, rfields(5'd15, 2'd0, isa_pkg::SLLI)), 0);
    run_instr(enc(isa_pkg::ORI, r, r, v[14:0]), 0);
  endtask

  // OR with r0 into r30
  task automatic readback(input isa_pkg::reg_idx_t r);
    run_instr(enc(isa_pkg::TYPE_BASIC, 5'd30, r, rfields(5'd0, 2'd0, isa_pkg::OR)), 0);
  endtask

  task automatic after_reset();
    check_flag("ack after reset", ack, 1'b0);
    check_word("result after reset", result, '0);
    check_flag("overflow after reset", overflow, 1'b0);
    check_flag("taken after reset", taken, 1'b0);
    run_instr(enc(isa_pkg::ORI, 5'd1, 5'd0, 15'd0), 0);
  endtask

  task automatic immediate_ops();
    run_instr(enc(isa_pkg::MOVI, 5'd2, 5'h10, 15'h0005), 0);
    check_word("movi sign extension", result, 32'hfff80005);
    readback(5'd2);
    run_instr(enc(isa_pkg::ORI, 5'd3, 5'd0, 15'h7abc), 0);
    check_word("ori zero extension", result, 32'h00007abc);
    readback(5'd3);
    run_instr(enc(isa_pkg::XORI, 5'd4, 5'd2, 15'h4321), 0);
    readback(5'd4);
    run_instr(enc(isa_pkg::ADDI, 5'd5, 5'd2, 15'h7ff0), 0);
    readback(5'd5);
    load_reg(5'd6, 32'h7fffffff);
    run_instr(enc(isa_pkg::ADDI, 5'd7, 5'd6, 15'd1), 0);
    check_flag("addi overflow", overflow, 1'b1);
  endtask

  task automatic register_ops();
    isa_pkg::word_t a;
    isa_pkg::word_t b;
    for (int i = 0; i < 20; i++) begin
      a = $random(seed);
      b = $random(seed);
      load_reg(5'd8, a);
      load_reg(5'd9, b);
      for (int k = 0; k < 5; k++) begin
        run_instr(enc(isa_pkg::TYPE_BASIC, 5'd10, 5'd8,
                      rfields(5'd9, 2'd0, BASIC_OPS[k[2:0]])), 0);
      end
    end
    // the two SUB corner cases
    load_reg(5'd8, 32'h80000000);
    run_instr(enc(isa_pkg::ADDI, 5'd9, 5'd0, 15'd1), 0);
    run_instr(enc(isa_pkg::TYPE_BASIC, 5'd10, 5'd8, rfields(5'd9, 2'd0, isa_pkg::SUB)), 0);
    check_flag("most negative minus one", overflow, 1'b1);
    run_instr(enc(isa_pkg::TYPE_BASIC, 5'd10, 5'd0, rfields(5'd8, 2'd0, isa_pkg::SUB)), 0);
    check_flag("zero minus most negative", overflow, 1'b1);
  endtask

  task automatic shift_ops();
    isa_pkg::word_t a;
    isa_pkg::word_t rnd;
    logic [4:0]     amt;
    a   = $random(seed);
    rnd = $random(seed);
    load_reg(5'd11, a);
    for (int j = 0; j < 4; j++) begin
      amt = (j == 0) ? 5'd0 : (j == 1) ? 5'd1 : (j == 2) ? 5'd31 : rnd[4:0];
      for (int k = 5; k < 8; k++) begin
        run_instr(enc(isa_pkg::TYPE_BASIC, 5'd12, 5'd11,
                      rfields(amt, 2'd0, BASIC_OPS[k[2:0]])), 0);
        if (amt == 5'd0) check_word("shift by zero", result, a);
      end
    end
  endtask

  task automatic branch_and_address_ops();
    load_reg(5'd13, 32'h12345678);
    load_reg(5'd14, 32'h12345678);
    run_instr(enc(isa_pkg::ORI, 5'd15, 5'd0, 15'h0040), 0);
    run_instr(enc(isa_pkg::BEQ, 5'd14, 5'd13, 15'd0), 0);
    check_flag("beq on equal operands", taken, 1'b1);
    run_instr(enc(isa_pkg::BEQ, 5'd15, 5'd13, 15'd0), 0);
    check_flag("beq on different operands", taken, 1'b0);
    run_instr(enc(isa_pkg::J, 5'd14, 5'd0, 15'd0), 0);
    check_flag("jump", taken, 1'b1);
    readback(5'd14);
    run_instr(enc(isa_pkg::LWI, 5'd15, 5'd13, 15'h0010), 0);
    check_word("lwi address", result, 32'h123456b8);
    run_instr(enc(isa_pkg::SWI, 5'd15, 5'd13, 15'h7fff), 0);
    check_word("swi address", result, 32'h12345674);
    for (int s = 0; s < 4; s++) begin
      run_instr(enc(isa_pkg::TYPE_LS, 5'd15, 5'd13,
                    rfields(5'd15, s[1:0], s[0] ? isa_pkg::SW : isa_pkg::LW)), 0);
      check_word("lw or sw address", result, 32'h12345678 + (32'h40 << s));
    end
    readback(5'd15);
  endtask

  task automatic handshake_and_undefined();
    load_reg(5'd16, 32'h0f0f1234);
    run_instr(enc(isa_pkg::TYPE_BASIC, 5'd17, 5'd16, rfields(5'd16, 2'd0, isa_pkg::ADD)), 10);
    run_instr(enc(6'h3f, 5'd16, 5'd16, rfields(5'd16, 2'd0, 5'h1f)), 0);
    check_word("undefined opcode", result, '0);
    run_instr(enc(isa_pkg::TYPE_BASIC, 5'd16, 5'd16, rfields(5'd16, 2'd0, 5'h1f)), 0);
    check_word("undefined sub-opcode", result, '0);
    readback(5'd16);
  endtask

  initial begin
    #(NUM_INSTR * 20 * CLK_PERIOD);
    $display("timeout: tests still running after %0d clock periods", NUM_INSTR * 20);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

  initial begin
    req        = 1'b0;
    instr      = '0;
    seed       = 58;
    model_regs = '{default: '0};
    @(posedge clk);
    while (reset) @(posedge clk);
    @(negedge clk);
    after_reset();
    immediate_ops();
    register_ops();
    shift_ops();
    branch_and_address_ops();
    handshake_and_undefined();
    $display("Done: no errors");
    $finish;
  end

endmodule

/* exec_stage.f */
logic/isa_pkg.sv
logic/alu32.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/exec_control.sv
logic/exec_stage.sv
dv/tb_clock_gen.sv
dv/exec_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds exec_stage_tb with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 --top-module exec_stage_tb \
  -f exec_stage.f --Mdir obj_dir -o exec_stage_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/exec_stage_sim > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "Done: errors found" "$log"; then
  echo "simulation failed"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
echo "simulation passed"
exit 0
